//--- project.f
src/rv_pkg.sv
src/rv_uop_if.sv
src/rv_apb_front.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_core_top.sv
dv/rv_checker.sv
dv/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_top
FILELIST  := project.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := No errors

SOURCES := $(wildcard src/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_top.sv
`timescale 1ns/1ns

module tb_top;
  import rv_pkg::*;

  localparam int t1_ops    = 48;
  localparam int t2_ops    = 16;
  localparam int t3_rounds = 4;
  localparam int t4_ops    = 8;
  localparam int n_err     = 7;
  // Every test ends with a sweep of all 32 registers
  localparam int planned_xfers = (1 + t1_ops + 32) + (2 * t2_ops + 33) +
                                 (5 * t3_rounds + 33) + (t4_ops + 35) + (n_err + 33);
  localparam int cycle_limit = 40 * planned_xfers + 10;

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic        pready;
  logic [31:0] prdata;
  logic        pslverr;
  int          error_count;
  int          check_count;
  int          cycle_count = 0;
  int          tests_run = 0;
  int          errors_at_start = 0;
  logic [31:0] lfsr_state = 32'h63d18275;

  rv_core_top #(
    .xlen_p (32)
  ) DUT (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .pready_o  (pready),
    .prdata_o  (prdata),
    .pslverr_o (pslverr)
  );

  rv_checker u_checker (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .paddr_i       (paddr),
    .pwdata_i      (pwdata),
    .pready_i      (pready),
    .prdata_i      (prdata),
    .pslverr_i     (pslverr),
    .error_count_o (error_count),
    .check_count_o (check_count)
  );

  initial
    clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, an APB transfer never completed", cycle_count);
      $display("Errors found");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // Starts and returns 10 ns after a rising edge
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #10;
    penable = 1'b1;
    @(negedge clk);
    while (!pready)
      @(negedge clk);
    @(posedge clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    apb_xfer(1'b1, addr, data);
  endtask

  task automatic apb_read(input logic [7:0] addr);
    apb_xfer(1'b0, addr, 32'd0);
  endtask

  task automatic read_all_regs();
    for (int i = 0; i < 32; i++)
      apb_read(ADDR_REG_BASE + 8'(4 * i));
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("Test %0d %s: %s, %0d mismatches", tests_run, name,
             (error_count == errors_at_start) ? "passed" : "failed",
             error_count - errors_at_start);
    errors_at_start = error_count;
  endtask

  task automatic alu_test();
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic        alt;
    apb_write(ADDR_INSTR, {12'(rand_bits(12)), 5'd0, 3'b000, 5'd0, 7'b0010011});    // x0 target
    for (int i = 0; i < t1_ops; i++)
    begin
      f3  = 3'(rand_bits(3));
      alt = 1'(rand_bits(1));
      f7  = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      if (rand_bits(1) == 32'd1)
        apb_write(ADDR_INSTR, {f7, 5'(rand_bits(5)), 5'(rand_bits(5)), f3,
                               5'(rand_bits(5)), 7'b0110011});
      else
      begin
        imm = 12'(rand_bits(12));
        if (f3 == 3'd1 || f3 == 3'd5)
          imm[11:5] = (f3 == 3'd5) ? {1'b0, alt, 5'd0} : 7'd0;    // Shift encodings
        apb_write(ADDR_INSTR, {imm, 5'(rand_bits(5)), f3, 5'(rand_bits(5)), 7'b0010011});
      end
    end
    read_all_regs();
    end_test("register and immediate arithmetic");
  endtask

  task automatic control_test();
    logic [2:0] f3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (int i = 0; i < t2_ops; i++)
    begin
      rs1 = 5'(rand_bits(5));
      rs2 = (rand_bits(1) == 32'd1) ? rs1 : 5'(rand_bits(5));    // Forces some equal operands
      f3  = 3'(rand_bits(3));
      if (f3[2:1] == 2'b01)
        f3[2] = 1'b1;
      case (3'(rand_bits(3)))
        3'd0:    apb_write(ADDR_INSTR, {20'(rand_bits(20)), 5'(rand_bits(5)), 7'b0110111});
        3'd1:    apb_write(ADDR_INSTR, {20'(rand_bits(20)), 5'(rand_bits(5)), 7'b0010111});
        3'd2:    apb_write(ADDR_INSTR, {20'(rand_bits(20)), 5'(rand_bits(5)), 7'b1101111});
        3'd3:    apb_write(ADDR_INSTR, {12'(rand_bits(12)), rs1, 3'b000, 5'(rand_bits(5)),
                                        7'b1100111});
        default: apb_write(ADDR_INSTR, {7'(rand_bits(7)), rs2, rs1, f3, 5'(rand_bits(5)),
                                        7'b1100011});
      endcase
      apb_read(ADDR_PC);
    end
    read_all_regs();
    apb_read(ADDR_PC);
    end_test("jumps and branches");
  endtask

  task automatic pc_write_test();
    for (int i = 0; i < t3_rounds; i++)
    begin
      apb_write(ADDR_INSTR, {12'(rand_bits(12)), 5'(rand_bits(5)), 3'b000,
                             5'(rand_bits(5)), 7'b0010011});
      apb_write(ADDR_INSTR, {12'(rand_bits(12)), 5'(rand_bits(5)), 3'b000,
                             5'(rand_bits(5)), 7'b0010011});
      apb_write(ADDR_PC, {30'(rand_bits(30)), 2'b00});    // Must wait for both
      apb_write(ADDR_INSTR, {20'(rand_bits(20)), 5'(rand_bits(4)) | 5'd16, 7'b0010111});
      apb_read(ADDR_PC);
    end
    read_all_regs();
    apb_read(ADDR_PC);
    end_test("PC write after back-to-back instructions");
  endtask

  task automatic illegal_test();
    logic [6:0] opc;
    for (int i = 0; i < t4_ops; i++)
    begin
      case (2'(rand_bits(2)))
        2'd0:    opc = 7'b0000011;    // Load
        2'd1:    opc = 7'b0100011;    // Store
        2'd2:    opc = 7'b0001111;    // FENCE
        default: opc = 7'b1110011;    // SYSTEM
      endcase
      apb_write(ADDR_INSTR, {25'(rand_bits(25)), opc});
    end
    apb_read(ADDR_PC);
    apb_read(ADDR_ILLEGAL);
    apb_read(ADDR_RETIRED);
    read_all_regs();
    end_test("illegal instructions");
  endtask

  task automatic slave_error_test();
    apb_read(8'h10);
    apb_read(8'h44);
    apb_read(8'h82);    // Misaligned register window
    apb_read(ADDR_INSTR);
    apb_write(ADDR_RETIRED, rand_bits(32));
    apb_write(ADDR_ILLEGAL, rand_bits(32));
    apb_write(ADDR_REG_BASE + 8'h14, rand_bits(32));
    read_all_regs();
    apb_read(ADDR_RETIRED);
    end_test("slave errors");
  endtask

  initial
  begin
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (10) @(posedge clk);
    #10;
    arst_n = 1'b1;
    alu_test();
    control_test();
    pc_write_test();
    illegal_test();
    slave_error_test();
    $display("Tests %0d, checks %0d, mismatches %0d", tests_run, check_count, error_count);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- dv/rv_checker.sv
`timescale 1ns/1ns

// Watches the APB port and compares read data against an ISA-level model
module rv_checker (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [7:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  input  logic        pready_i,
  input  logic [31:0] prdata_i,
  input  logic        pslverr_i,
  output int          error_count_o,
  output int          check_count_o
);
  import rv_pkg::*;

  logic [31:0] m_regs [0:31];    // m_regs[0] is never written
  logic [31:0] m_pc;
  logic [31:0] m_retired;
  logic [31:0] m_illegal;
  int          cycle_n = 0;
  int          access_start = 0;
  int          last_accept = -8;

  initial
  begin
    error_count_o = 0;
    check_count_o = 0;
  end

  function automatic void reset_model();
    for (int i = 0; i < 32; i++)
      m_regs[i] = '0;
    m_pc      = '0;
    m_retired = '0;
    m_illegal = '0;
  endfunction

  function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Executes one instruction word on the model
  function automatic void exec_instr(input logic [31:0] w);
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic        wr;
    logic        legal;
    f3      = w[14:12];
    a       = m_regs[w[19:15]];
    b       = m_regs[w[24:20]];
    imm_i   = {{20{w[31]}}, w[31:20]};
    imm_u   = {w[31:12], 12'd0};
    imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    res     = '0;
    wr      = 1'b0;
    legal   = 1'b1;
    next_pc = m_pc + 32'd4;
    case (w[6:0])
      7'b0110011:
      begin
        res = alu(f3, w[30] && (f3 == 3'd0 || f3 == 3'd5), a, b);
        wr  = 1'b1;
      end
      7'b0010011:
      begin
        res = alu(f3, w[30] && (f3 == 3'd5), a, imm_i);
        wr  = 1'b1;
      end
      7'b0110111:
      begin
        res = imm_u;
        wr  = 1'b1;
      end
      7'b0010111:
      begin
        res = m_pc + imm_u;
        wr  = 1'b1;
      end
      7'b1101111:
      begin
        res     = m_pc + 32'd4;
        wr      = 1'b1;
        next_pc = m_pc + imm_j;
      end
      7'b1100111:
      begin
        legal   = (f3 == 3'd0);
        res     = m_pc + 32'd4;
        wr      = 1'b1;
        next_pc = legal ? ((a + imm_i) & ~32'd1) : next_pc;
      end
      7'b1100011:
      begin
        legal = (f3[2:1] != 2'b01);
        if (legal && branch_taken(f3, a, b))
          next_pc = m_pc + imm_b;
      end
      default: legal = 1'b0;    // Loads, stores, FENCE, SYSTEM and the rest
    endcase
    if (wr && legal && (w[11:7] != 5'd0))
      m_regs[w[11:7]] = res;
    m_retired = m_retired + 32'd1;
    if (!legal)
      m_illegal = m_illegal + 32'd1;
    m_pc = next_pc;
  endfunction

  function automatic logic expect_error(input logic [7:0] addr, input logic wr);
    logic ro;
    logic mapped;
    ro     = (addr == ADDR_RETIRED) || (addr == ADDR_ILLEGAL) ||
             ((addr >= ADDR_REG_BASE) && (addr[1:0] == 2'b00));
    mapped = ro || (addr == ADDR_INSTR) || (addr == ADDR_PC);
    return !mapped || (wr && ro) || (!wr && (addr == ADDR_INSTR));
  endfunction

  // Register-side accesses end three cycles after the last accepted instruction
  function automatic void check_latency(input logic [7:0] addr, input logic wr);
    int exp_cycle;
    exp_cycle = access_start;
    if (!expect_error(addr, wr) && !(wr && (addr == ADDR_INSTR)) &&
        (last_accept + 3 > exp_cycle))
      exp_cycle = last_accept + 3;
    check_count_o++;
    if (cycle_n != exp_cycle)
    begin
      error_count_o++;
      $display("%0t ns: %s of address 0x%02h took %0d access cycles instead of %0d",
               $time, wr ? "write" : "read", addr, cycle_n - access_start + 1,
               exp_cycle - access_start + 1);
    end
  endfunction

  function automatic void compare_read(input logic [7:0] addr, input logic [31:0] got);
    logic [31:0] exp;
    string       name;
    if (addr == ADDR_PC)
    begin
      exp  = m_pc;
      name = "PC";
    end
    else if (addr == ADDR_RETIRED)
    begin
      exp  = m_retired;
      name = "RETIRED";
    end
    else if (addr == ADDR_ILLEGAL)
    begin
      exp  = m_illegal;
      name = "ILLEGAL";
    end
    else
    begin
      exp  = m_regs[addr[6:2]];
      name = $sformatf("x%0d", addr[6:2]);
    end
    check_count_o++;
    if (got !== exp)
    begin
      error_count_o++;
      $display("[ERROR] %0t ns prdata_o %s: got 0x%08h, expected 0x%08h",
               $time, name, got, exp);
    end
  endfunction

  // APB signals are settled at mid-cycle
  always @(negedge clk_i)
  begin
    cycle_n++;
    if (!arst_n_i)
    begin
      reset_model();
      last_accept = -8;
    end
    else if (psel_i && !penable_i)
      access_start = cycle_n + 1;    // Access phase follows setup
    else if (psel_i && penable_i && pready_i)
    begin
      check_latency(paddr_i, pwrite_i);
      if (pslverr_i !== expect_error(paddr_i, pwrite_i))
      begin
        error_count_o++;
        $display("%0t ns: slave error flag was %b on a %s of address 0x%02h, expected %b",
                 $time, pslverr_i, pwrite_i ? "write" : "read", paddr_i,
                 expect_error(paddr_i, pwrite_i));
      end
      else if (!pslverr_i && pwrite_i && (paddr_i == ADDR_INSTR))
      begin
        exec_instr(pwdata_i);
        last_accept = cycle_n;
      end
      else if (!pslverr_i && pwrite_i && (paddr_i == ADDR_PC))
        m_pc = pwdata_i;
      else if (!pslverr_i && !pwrite_i)
        compare_read(paddr_i, prdata_i);
    end
  end

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top #(
  parameter int xlen_p = rv_pkg::xlen_default
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [7:0]        paddr_i,
  input  logic [xlen_p-1:0] pwdata_i,
  output logic              pready_o,
  output logic [xlen_p-1:0] prdata_o,
  output logic              pslverr_o
);

  logic              instr_valid;
  logic [31:0]       instr;
  logic              retire;
  logic [xlen_p-1:0] pc;
  logic [xlen_p-1:0] retired_count;
  logic [xlen_p-1:0] illegal_count;
  logic [4:0]        reg_raddr;
  logic [xlen_p-1:0] reg_rdata;
  logic              pc_wr;
  logic [xlen_p-1:0] pc_wdata;

  rv_uop_if uop_if ();

  rv_apb_front #(
    .xlen_p (xlen_p)
  ) u_front (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .pready_o        (pready_o),
    .prdata_o        (prdata_o),
    .pslverr_o       (pslverr_o),
    .instr_valid_o   (instr_valid),
    .instr_o         (instr),
    .retire_i        (retire),
    .pc_i            (pc),
    .retired_count_i (retired_count),
    .illegal_count_i (illegal_count),
    .reg_raddr_o     (reg_raddr),
    .reg_rdata_i     (reg_rdata),
    .pc_wr_o         (pc_wr),
    .pc_wdata_o      (pc_wdata)
  );

  rv_decode u_decode (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .uop           (uop_if.producer)
  );

  rv_execute #(
    .xlen_p (xlen_p)
  ) u_execute (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .uop             (uop_if.consumer),
    .retire_o        (retire),
    .pc_o            (pc),
    .retired_count_o (retired_count),
    .illegal_count_o (illegal_count),
    .reg_raddr_i     (reg_raddr),
    .reg_rdata_o     (reg_rdata),
    .pc_wr_i         (pc_wr),
    .pc_wdata_i      (pc_wdata)
  );

endmodule

//--- src/rv_execute.sv
`timescale 1ns/1ns

module rv_execute #(
  parameter int xlen_p = rv_pkg::xlen_default
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  rv_uop_if.consumer        uop,
  output logic              retire_o,
  output logic [xlen_p-1:0] pc_o,
  output logic [xlen_p-1:0] retired_count_o,
  output logic [xlen_p-1:0] illegal_count_o,
  input  logic [4:0]        reg_raddr_i,
  output logic [xlen_p-1:0] reg_rdata_o,
  input  logic              pc_wr_i,
  input  logic [xlen_p-1:0] pc_wdata_i
);
  import rv_pkg::*;

  localparam int shamt_w = $clog2(xlen_p);

  logic [xlen_p-1:0] regs_q [31:1];    // x0 is not stored
  logic [xlen_p-1:0] pc_q;
  logic [xlen_p-1:0] retired_q;
  logic [xlen_p-1:0] illegal_q;
  logic [xlen_p-1:0] rs1_val;
  logic [xlen_p-1:0] rs2_val;
  logic [xlen_p-1:0] imm_x;
  logic [xlen_p-1:0] op_b;
  logic [shamt_w-1:0] shamt;
  logic [xlen_p-1:0] alu_res;
  logic [xlen_p-1:0] pc_plus4;
  logic [xlen_p-1:0] pc_rel;
  logic [xlen_p-1:0] jalr_target;
  logic [xlen_p-1:0] pc_next;
  logic [xlen_p-1:0] rd_val;
  logic              rd_we;
  logic              taken;
  uop_t              u;

  assign u = uop.uop;

  // Register reads
  assign rs1_val     = (u.rs1 == 5'd0) ? '0 : regs_q[u.rs1];
  assign rs2_val     = (u.rs2 == 5'd0) ? '0 : regs_q[u.rs2];
  assign reg_rdata_o = (reg_raddr_i == 5'd0) ? '0 : regs_q[reg_raddr_i];

  assign imm_x = xlen_p'(signed'(u.imm));
  assign op_b  = (u.kind == UOP_ALU_REG) ? rs2_val : imm_x;
  assign shamt = op_b[shamt_w-1:0];

  always_comb
  begin
    case (u.alu_op)
      ALU_ADD:  alu_res = rs1_val + op_b;
      ALU_SUB:  alu_res = rs1_val - op_b;
      ALU_SLL:  alu_res = rs1_val << shamt;
      ALU_SLT:  alu_res = xlen_p'($signed(rs1_val) < $signed(op_b));
      ALU_SLTU: alu_res = xlen_p'(rs1_val < op_b);
      ALU_XOR:  alu_res = rs1_val ^ op_b;
      ALU_SRL:  alu_res = rs1_val >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(rs1_val) >>> shamt);
      ALU_OR:   alu_res = rs1_val | op_b;
      ALU_AND:  alu_res = rs1_val & op_b;
      default:  alu_res = '0;
    endcase
  end

  // Branch compare
  always_comb
  begin
    case (u.br_cond)
      BR_EQ:   taken = (rs1_val == rs2_val);
      BR_NE:   taken = (rs1_val != rs2_val);
      BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
      BR_GE:   taken = ($signed(rs1_val) >= $signed(rs2_val));
      BR_LTU:  taken = (rs1_val < rs2_val);
      BR_GEU:  taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4    = pc_q + xlen_p'(4);
  assign pc_rel      = pc_q + imm_x;    // JAL, branch and AUIPC
  assign jalr_target = (rs1_val + imm_x) & ~xlen_p'(1);

  always_comb
  begin
    pc_next = pc_plus4;
    rd_val  = '0;
    rd_we   = 1'b0;
    case (u.kind)
      UOP_ALU_REG, UOP_ALU_IMM:
      begin
        rd_val = alu_res;
        rd_we  = 1'b1;
      end
      UOP_LUI:
      begin
        rd_val = imm_x;
        rd_we  = 1'b1;
      end
      UOP_AUIPC:
      begin
        rd_val = pc_rel;
        rd_we  = 1'b1;
      end
      UOP_JAL:
      begin
        rd_val  = pc_plus4;    // Link
        rd_we   = 1'b1;
        pc_next = pc_rel;
      end
      UOP_JALR:
      begin
        rd_val  = pc_plus4;
        rd_we   = 1'b1;
        pc_next = jalr_target;
      end
      UOP_BRANCH:
      begin
        if (taken)
          pc_next = pc_rel;
      end
      default: ;    // Illegal skips over
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 1; i < 32; i++)
        regs_q[i] <= '0;
    end
    else if (uop.valid && rd_we && (u.rd != 5'd0))
      regs_q[u.rd] <= rd_val;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pc_q      <= '0;
      retired_q <= '0;
      illegal_q <= '0;
    end
    else
    begin
      if (pc_wr_i)
        pc_q <= pc_wdata_i;    // Host write
      else if (uop.valid)
        pc_q <= pc_next;
      if (uop.valid)
        retired_q <= retired_q + xlen_p'(1);
      if (uop.valid && (u.kind == UOP_ILLEGAL))
        illegal_q <= illegal_q + xlen_p'(1);
    end
  end

  assign retire_o        = uop.valid;
  assign pc_o            = pc_q;
  assign retired_count_o = retired_q;
  assign illegal_count_o = illegal_q;

  // Front end holds PC writes until the pipeline is empty
  a_pc_wr_idle: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !(pc_wr_i && uop.valid)
  );

endmodule

//--- src/rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  rv_uop_if.producer  uop
);
  import rv_pkg::*;

  logic [4:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_u;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic        sub_sra_reg;
  logic        sra_imm;
  uop_t        uop_d;
  uop_t        uop_q;
  logic        valid_q;

  // Field split
  assign opcode = instr_i[6:2];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  // Sign bit of every immediate is instr[31]
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // funct7[5] only selects SUB/SRA on add and right-shift slots
  assign sub_sra_reg = funct7[5] & ((funct3 == 3'b000) | (funct3 == 3'b101));
  assign sra_imm     = funct7[5] & (funct3 == 3'b101);

  always_comb
  begin
    uop_d         = '0;
    uop_d.kind    = UOP_ILLEGAL;
    uop_d.alu_op  = ALU_ADD;
    uop_d.br_cond = BR_EQ;
    if (instr_i[1:0] == 2'b11)    // 32-bit encodings only
    begin
      case (opcode)
        OPC_OP:
        begin
          uop_d.kind   = UOP_ALU_REG;
          uop_d.alu_op = alu_op_e'({sub_sra_reg, funct3});
          uop_d.rd     = rd;
          uop_d.rs1    = rs1;
          uop_d.rs2    = rs2;
        end
        OPC_OP_IMM:
        begin
          uop_d.kind   = UOP_ALU_IMM;
          uop_d.alu_op = alu_op_e'({sra_imm, funct3});
          uop_d.rd     = rd;
          uop_d.rs1    = rs1;
          uop_d.imm    = imm_i;    // Shifts use imm[4:0]
        end
        OPC_LUI:
        begin
          uop_d.kind = UOP_LUI;
          uop_d.rd   = rd;
          uop_d.imm  = imm_u;
        end
        OPC_AUIPC:
        begin
          uop_d.kind = UOP_AUIPC;
          uop_d.rd   = rd;
          uop_d.imm  = imm_u;
        end
        OPC_JAL:
        begin
          uop_d.kind = UOP_JAL;
          uop_d.rd   = rd;
          uop_d.imm  = imm_j;
        end
        OPC_JALR:
        begin
          if (funct3 == 3'b000)
          begin
            uop_d.kind = UOP_JALR;
            uop_d.rd   = rd;
            uop_d.rs1  = rs1;
            uop_d.imm  = imm_i;
          end
        end
        OPC_BRANCH:
        begin
          if (funct3[2:1] != 2'b01)    // 010 and 011 are reserved
          begin
            uop_d.kind    = UOP_BRANCH;
            uop_d.br_cond = br_cond_e'(funct3);
            uop_d.rs1     = rs1;
            uop_d.rs2     = rs2;
            uop_d.imm     = imm_b;
          end
        end
        OPC_LOAD, OPC_STORE, OPC_MISC_MEM, OPC_SYSTEM:
        begin
          // No memory or CSR side to act on
          uop_d.imm = imm_s;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_q <= 1'b0;
    else
      valid_q <= instr_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (instr_valid_i)
      uop_q <= uop_d;
  end

  assign uop.valid = valid_q;
  assign uop.uop   = uop_q;

  // APB pacing keeps at least one idle cycle between micro-ops
  a_no_back_to_back: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) valid_q |=> !valid_q
  );

endmodule

//--- src/rv_apb_front.sv
`timescale 1ns/1ns

module rv_apb_front #(
  parameter int xlen_p = rv_pkg::xlen_default
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [7:0]        paddr_i,
  input  logic [xlen_p-1:0] pwdata_i,
  output logic              pready_o,
  output logic [xlen_p-1:0] prdata_o,
  output logic              pslverr_o,
  output logic              instr_valid_o,
  output logic [31:0]       instr_o,
  input  logic              retire_i,
  input  logic [xlen_p-1:0] pc_i,
  input  logic [xlen_p-1:0] retired_count_i,
  input  logic [xlen_p-1:0] illegal_count_i,
  output logic [4:0]        reg_raddr_o,
  input  logic [xlen_p-1:0] reg_rdata_i,
  output logic              pc_wr_o,
  output logic [xlen_p-1:0] pc_wdata_o
);
  import rv_pkg::*;

  logic       access;
  logic       is_instr;
  logic       is_pc;
  logic       is_retired;
  logic       is_illegal;
  logic       is_reg;
  logic       mapped;
  logic       read_only;
  logic       slv_err;
  logic       idle;
  logic       instr_accept;
  logic       read_done;
  logic [1:0] outstanding_q;

  assign access = psel_i & penable_i;

  // Address decode
  assign is_instr   = (paddr_i == ADDR_INSTR);
  assign is_pc      = (paddr_i == ADDR_PC);
  assign is_retired = (paddr_i == ADDR_RETIRED);
  assign is_illegal = (paddr_i == ADDR_ILLEGAL);
  assign is_reg     = ((paddr_i & ADDR_REG_BASE) == ADDR_REG_BASE) && (paddr_i[1:0] == 2'b00);

  assign mapped    = is_instr | is_pc | is_retired | is_illegal | is_reg;
  assign read_only = is_retired | is_illegal | is_reg;
  assign slv_err   = !mapped | (pwrite_i & read_only) | (!pwrite_i & is_instr);

  // Register-side accesses wait for the pipeline to drain
  assign idle = (outstanding_q == 2'd0);

  assign instr_accept = access & pwrite_i & is_instr;
  assign read_done    = access & !pwrite_i & !slv_err & idle;

  assign pready_o  = access & (slv_err | instr_accept | idle);
  assign pslverr_o = access & slv_err;

  assign pc_wr_o     = access & pwrite_i & is_pc & idle;
  assign pc_wdata_o  = pwdata_i;
  assign reg_raddr_o = paddr_i[6:2];

  always_comb
  begin
    prdata_o = '0;
    if (read_done)
    begin
      if (is_pc)
        prdata_o = pc_i;
      else if (is_retired)
        prdata_o = retired_count_i;
      else if (is_illegal)
        prdata_o = illegal_count_i;
      else
        prdata_o = reg_rdata_i;    // Register window
    end
  end

  // One-cycle instruction hand-off to decode
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      instr_valid_o <= 1'b0;
    else
      instr_valid_o <= instr_accept;
  end

  always_ff @(posedge clk_i)
  begin
    if (instr_accept)
      instr_o <= pwdata_i[31:0];
  end

  // Instructions in flight
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      outstanding_q <= 2'd0;
    else
    begin
      case ({instr_accept, retire_i})
        2'b10:   outstanding_q <= outstanding_q + 2'd1;
        2'b01:   outstanding_q <= outstanding_q - 2'd1;
        default: outstanding_q <= outstanding_q;    // Both or neither
      endcase
    end
  end

  // Every retire from execute matches an earlier accept
  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) retire_i |-> (outstanding_q != 2'd0)
  );

endmodule

//--- src/rv_uop_if.sv
`timescale 1ns/1ns

// Decoded micro-op from decoder to execute stage
interface rv_uop_if;
  import rv_pkg::*;

  logic valid;
  uop_t uop;

  modport producer (
    output valid,
    output uop
  );

  modport consumer (
    input valid,
    input uop
  );

endinterface

//--- src/rv_pkg.sv
package rv_pkg;

  parameter int xlen_default = 32;

  // Major opcode in instruction bits [6:2]
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00000,
    OPC_MISC_MEM = 5'b00011,
    OPC_OP_IMM   = 5'b00100,
    OPC_AUIPC    = 5'b00101,
    OPC_STORE    = 5'b01000,
    OPC_OP       = 5'b01100,
    OPC_LUI      = 5'b01101,
    OPC_BRANCH   = 5'b11000,
    OPC_JALR     = 5'b11001,
    OPC_JAL      = 5'b11011,
    OPC_SYSTEM   = 5'b11100
  } opcode_e;

  typedef enum logic [2:0] {
    UOP_ALU_REG,
    UOP_ALU_IMM,
    UOP_LUI,
    UOP_AUIPC,
    UOP_JAL,
    UOP_JALR,
    UOP_BRANCH,
    UOP_ILLEGAL
  } uop_kind_e;

  // Encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

  typedef struct packed {
    uop_kind_e   kind;
    alu_op_e     alu_op;
    br_cond_e    br_cond;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;    // Already sign-extended
  } uop_t;

  // APB register map
  localparam logic [7:0] ADDR_INSTR    = 8'h00;
  localparam logic [7:0] ADDR_PC       = 8'h04;
  localparam logic [7:0] ADDR_RETIRED  = 8'h08;
  localparam logic [7:0] ADDR_ILLEGAL  = 8'h0C;
  localparam logic [7:0] ADDR_REG_BASE = 8'h80;

endpackage
